/* tb.f */
verilog/io_cmd_pkg.sv
verilog/io_tlm_pkg.sv
verilog/key_debounce.sv
verilog/led_flash.sv
verilog/tr_control.sv
verilog/telemetry_regs.sv
verilog/resp_builder.sv
verilog/io_block.sv
test/tb_io_block.sv

/* test/tb_io_block.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_io_block;

  localparam logic [7:0]  SERIAL_NO       = 8'h2a;
  localparam int unsigned DEBOUNCE_CYCLES = 8;
  localparam int unsigned FLASH_CYCLES    = 16;
  localparam int          CLK_PERIOD      = 100;
  localparam int          N_TESTS         = 6;
  localparam int          KEY_CW          = 0;
  localparam int          KEY_INH         = 1;
  localparam int          KEY_EXT         = 2;

  logic                              clk;
  logic                              rst_n_i;
  logic                              cmd_rqst_i;
  logic [io_cmd_pkg::CMD_ADDR_W-1:0] cmd_addr_i;
  logic [io_cmd_pkg::CMD_DATA_W-1:0] cmd_data_i;
  logic                              cmd_ptt_i;
  logic                              cmd_requires_resp_i;
  logic                              cmd_ack_ext_i;
  logic                              resp_rqst_i;
  logic [io_cmd_pkg::RESP_W-1:0]     resp_o;
  logic                              adc_valid_i;
  io_tlm_pkg::tlm_chan_e             adc_chan_i;
  logic [io_tlm_pkg::ADC_W-1:0]      adc_data_i;
  logic                              phone_tip_n_i;
  logic                              phone_ring_n_i;
  logic                              txinhibit_n_i;
  logic                              rxclip_p_i;
  logic                              rxclip_n_i;
  logic                              this_mac_i;
  logic                              run_i;
  logic                              cwkey_o;
  logic                              ext_ptt_o;
  logic                              txinhibit_o;
  logic                              db_cwkey_o;
  logic                              led_d2_o;
  logic                              led_d3_o;
  logic                              led_d4_o;
  logic                              led_d5_o;
  logic                              pa_inttr_o;
  logic                              pa_exttr_o;
  logic                              pwr_envpa_o;
  logic                              pwr_envop_o;
  logic                              pwr_envbias_o;
  logic                              rffe_rfsw_sel_o;

  integer seed;

  // Reference model state
  logic [5:0]  m_addr;
  logic [31:0] m_data;
  logic        m_req_resp;
  logic        m_pending;
  logic [1:0]  m_slot;
  logic        m_cmd_ptt;
  logic        m_vna;
  logic        m_pa_en;
  logic        m_tr_dis;
  logic        m_cwkey;
  logic        m_ext_ptt;
  logic        m_inhibit;
  logic        m_clip;
  logic [11:0] m_fwd;
  logic [11:0] m_temp;
  logic [11:0] m_bias;
  logic [11:0] m_rev;

  io_block #(
    .SERIAL_NO(SERIAL_NO),
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
    .FLASH_CYCLES(FLASH_CYCLES)
  ) i_dut (
    .clk, .rst_n_i,
    .cmd_rqst_i, .cmd_addr_i, .cmd_data_i, .cmd_ptt_i, .cmd_requires_resp_i,
    .cmd_ack_ext_i, .resp_rqst_i, .resp_o,
    .adc_valid_i, .adc_chan_i, .adc_data_i,
    .phone_tip_n_i, .phone_ring_n_i, .txinhibit_n_i,
    .rxclip_p_i, .rxclip_n_i, .this_mac_i, .run_i,
    .cwkey_o, .ext_ptt_o, .txinhibit_o, .db_cwkey_o,
    .led_d2_o, .led_d3_o, .led_d4_o, .led_d5_o,
    .pa_inttr_o, .pa_exttr_o, .pwr_envpa_o, .pwr_envop_o, .pwr_envbias_o,
    .rffe_rfsw_sel_o
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Generous bound on the whole run
  initial begin
    #((N_TESTS * 200 + FLASH_CYCLES + DEBOUNCE_CYCLES) * CLK_PERIOD);
    $display("Timeout: the tests did not complete in the expected time");
    $display("test failed");
    $fatal(1, "Watchdog expired");
  end

  task automatic check(input string name, input logic [39:0] actual,
                       input logic [39:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
      $display("test failed");
      $fatal(1, "Mismatch");
    end
  endtask

  function automatic logic model_ptt();
    model_ptt = (m_cmd_ptt | m_cwkey | m_ext_ptt) & ~m_inhibit;
  endfunction

  function automatic logic [31:0] slot_payload(input logic [1:0] slot);
    case (slot)
      io_tlm_pkg::SLOT_ID:
        slot_payload = {(8'h1e & 8'hfe) | {7'd0, m_clip}, 8'h00, 8'h00, SERIAL_NO};
      io_tlm_pkg::SLOT_TEMP_FWD: slot_payload = {4'h0, m_temp, 4'h0, m_fwd};
      io_tlm_pkg::SLOT_REV_BIAS: slot_payload = {4'h0, m_rev, 4'h0, m_bias};
      default:                   slot_payload = 32'h0;
    endcase
  endfunction

  function automatic logic key_level(input int which);
    case (which)
      KEY_CW:  key_level = cwkey_o;
      KEY_EXT: key_level = ext_ptt_o;
      default: key_level = txinhibit_o;
    endcase
  endfunction

  task automatic wait_key(input int which, input logic value, input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (key_level(which) !== value && n < 4 * DEBOUNCE_CYCLES) begin
      @(negedge clk);
      n++;
    end
    check(name, key_level(which), value);
  endtask

  task automatic send_cmd(input logic [5:0] addr, input logic [31:0] data,
                          input logic ptt, input logic req);
    @(posedge clk);
    cmd_rqst_i          <= 1'b1;
    cmd_addr_i          <= addr;
    cmd_data_i          <= data;
    cmd_ptt_i           <= ptt;
    cmd_requires_resp_i <= req;
    @(posedge clk);
    cmd_rqst_i <= 1'b0;
    m_addr     = addr;
    m_data     = data;
    m_cmd_ptt  = ptt;
    m_req_resp = req;
    if (addr == io_cmd_pkg::CMD_TR_CFG) begin
      m_vna    = data[io_cmd_pkg::VNA_BIT];
      m_pa_en  = data[io_cmd_pkg::PA_EN_BIT];
      m_tr_dis = data[io_cmd_pkg::TR_DIS_BIT];
    end
  endtask

  task automatic send_ack;
    @(posedge clk);
    cmd_ack_ext_i <= 1'b1;
    @(posedge clk);
    cmd_ack_ext_i <= 1'b0;
    if (m_req_resp)
      m_pending = 1'b1;
  endtask

  task automatic write_sample(input logic [1:0] ch, input logic [11:0] data);
    @(posedge clk);
    adc_valid_i <= 1'b1;
    adc_chan_i  <= io_tlm_pkg::tlm_chan_e'(ch);
    adc_data_i  <= data;
    @(posedge clk);
    adc_valid_i <= 1'b0;
    case (ch)
      io_tlm_pkg::CH_FWD_PWR: m_fwd  = data;
      io_tlm_pkg::CH_TEMP:    m_temp = data;
      io_tlm_pkg::CH_BIAS:    m_bias = data;
      default:                m_rev  = data;
    endcase
  endtask

  task automatic request_and_check;
    logic [39:0] exp;
    @(posedge clk);
    resp_rqst_i <= 1'b1;
    @(posedge clk);
    resp_rqst_i <= 1'b0;
    if (m_pending) begin
      exp       = {1'b1, m_addr, model_ptt(), m_data};
      m_pending = 1'b0;
    end else begin
      exp = {3'b000, m_slot, 2'b00, model_ptt(), slot_payload(m_slot)};
    end
    m_slot = m_slot + 2'd1;  // Advances on every request
    @(negedge clk);
    check("resp_o", resp_o, exp);
  endtask

  task automatic check_tx_outputs;
    logic ptt;
    ptt = model_ptt();
    check("pa_exttr_o", pa_exttr_o, ptt);
    check("pa_inttr_o", pa_inttr_o, ptt & (m_pa_en | ~m_tr_dis));
    check("pwr_envpa_o", pwr_envpa_o, ptt & m_pa_en);
    check("pwr_envbias_o", pwr_envbias_o, ptt & m_pa_en);
    check("pwr_envop_o", pwr_envop_o, ptt | (m_vna & ~m_inhibit));
    check("rffe_rfsw_sel_o", rffe_rfsw_sel_o, m_pa_en);
  endtask

  task automatic test_reset;
    @(negedge clk);
    check("resp_o", resp_o, {8'h00, 8'h1e, 8'h00, 8'h00, SERIAL_NO});
    check_tx_outputs();
    check("cwkey_o", cwkey_o, 1'b0);
    check("ext_ptt_o", ext_ptt_o, 1'b0);
    check("txinhibit_o", txinhibit_o, 1'b0);
    check("led_d2_o", led_d2_o, 1'b1);
    check("led_d3_o", led_d3_o, 1'b1);
    check("led_d4_o", led_d4_o, 1'b1);
    check("led_d5_o", led_d5_o, 1'b1);
  endtask

  task automatic test_telemetry;
    for (int ch = 0; ch < 4; ch++)
      write_sample(ch[1:0], 12'($random(seed)));
    repeat (4) request_and_check();
  endtask

  task automatic test_cmd_resp;
    logic [1:0] n;
    send_cmd(6'h12, $random(seed), 1'b0, 1'b1);
    send_ack();
    n = m_slot;
    request_and_check();  // Command response takes slot n
    request_and_check();
    check("resp_o slot", resp_o[36:35], 2'(n + 2'd1));
    // No response wanted, so the ack is ignored
    send_cmd(6'h05, $random(seed), 1'b0, 1'b0);
    send_ack();
    request_and_check();
  endtask

  task automatic test_tr_control;
    logic [31:0] data;
    for (int combo = 0; combo < 8; combo++) begin
      for (int p = 0; p < 2; p++) begin
        data = $random(seed);
        data[io_cmd_pkg::VNA_BIT]    = combo[2];
        data[io_cmd_pkg::PA_EN_BIT]  = combo[1];
        data[io_cmd_pkg::TR_DIS_BIT] = combo[0];
        send_cmd(io_cmd_pkg::CMD_TR_CFG, data, p[0], 1'b0);
        @(negedge clk);
        check_tx_outputs();
      end
    end
    data = 32'h0;
    data[io_cmd_pkg::PA_EN_BIT] = 1'b1;  // Leave the PA enabled for keying
    send_cmd(io_cmd_pkg::CMD_TR_CFG, data, 1'b0, 1'b0);
    @(negedge clk);
    check_tx_outputs();
  endtask

  task automatic test_debounce;
    logic [31:0] data;
    @(posedge clk);
    phone_tip_n_i <= 1'b0;
    repeat (DEBOUNCE_CYCLES / 2) @(posedge clk);
    phone_tip_n_i <= 1'b1;  // Glitch too short to pass
    repeat (DEBOUNCE_CYCLES + 6) begin
      @(negedge clk);
      check("cwkey_o", cwkey_o, 1'b0);
    end
    @(posedge clk);
    phone_tip_n_i <= 1'b0;
    wait_key(KEY_CW, 1'b1, "cwkey_o");
    m_cwkey = 1'b1;
    check("db_cwkey_o", db_cwkey_o, 1'b1);
    check_tx_outputs();
    request_and_check();
    check("resp_o ptt", resp_o[32], 1'b1);
    @(posedge clk);
    txinhibit_n_i <= 1'b0;
    wait_key(KEY_INH, 1'b1, "txinhibit_o");
    m_inhibit = 1'b1;
    check_tx_outputs();
    data = 32'h0;
    data[io_cmd_pkg::VNA_BIT]   = 1'b1;  // Envelope supply drops in VNA mode too
    data[io_cmd_pkg::PA_EN_BIT] = 1'b1;
    send_cmd(io_cmd_pkg::CMD_TR_CFG, data, 1'b0, 1'b0);
    @(negedge clk);
    check_tx_outputs();
    request_and_check();
    @(posedge clk);
    phone_tip_n_i <= 1'b1;
    txinhibit_n_i <= 1'b1;
    wait_key(KEY_CW, 1'b0, "cwkey_o");
    wait_key(KEY_INH, 1'b0, "txinhibit_o");
    m_cwkey   = 1'b0;
    m_inhibit = 1'b0;
    // External PTT keys the radio on its own
    @(posedge clk);
    phone_ring_n_i <= 1'b0;
    wait_key(KEY_EXT, 1'b1, "ext_ptt_o");
    m_ext_ptt = 1'b1;
    check_tx_outputs();
    request_and_check();
    @(posedge clk);
    phone_ring_n_i <= 1'b1;
    wait_key(KEY_EXT, 1'b0, "ext_ptt_o");
    m_ext_ptt = 1'b0;
  endtask

  task automatic test_led_clip;
    @(posedge clk);
    rxclip_p_i <= 1'b1;
    @(posedge clk);
    rxclip_p_i <= 1'b0;
    m_clip = 1'b1;
    @(negedge clk);
    check("led_d4_o", led_d4_o, 1'b0);
    while (m_slot != io_tlm_pkg::SLOT_ID)
      request_and_check();
    request_and_check();  // Identity slot with clip flag
    repeat (FLASH_CYCLES + 4) @(negedge clk);
    check("led_d4_o", led_d4_o, 1'b1);
    check("led_d5_o", led_d5_o, 1'b1);
    m_clip = 1'b0;
    repeat (4) request_and_check();
  endtask

  initial begin
    seed                = 32'h8008_080d;
    rst_n_i             = 1'b0;
    cmd_rqst_i          = 1'b0;
    cmd_addr_i          = '0;
    cmd_data_i          = '0;
    cmd_ptt_i           = 1'b0;
    cmd_requires_resp_i = 1'b0;
    cmd_ack_ext_i       = 1'b0;
    resp_rqst_i         = 1'b0;
    adc_valid_i         = 1'b0;
    adc_chan_i          = io_tlm_pkg::CH_FWD_PWR;
    adc_data_i          = '0;
    phone_tip_n_i       = 1'b1;  // Keys released
    phone_ring_n_i      = 1'b1;
    txinhibit_n_i       = 1'b1;
    rxclip_p_i          = 1'b0;
    rxclip_n_i          = 1'b0;
    this_mac_i          = 1'b0;
    run_i               = 1'b0;
    {m_addr, m_data, m_req_resp, m_pending, m_slot, m_cmd_ptt} = '0;
    {m_vna, m_pa_en, m_tr_dis, m_cwkey, m_ext_ptt, m_inhibit, m_clip} = '0;
    {m_fwd, m_temp, m_bias, m_rev} = '0;
    repeat (3) @(posedge clk);
    rst_n_i <= 1'b1;
    test_reset();
    test_telemetry();
    test_cmd_resp();
    test_tr_control();
    test_debounce();
    test_led_clip();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/io_block.sv */
`timescale 1ns/100ps
`default_nettype none

module io_block #(
  parameter logic [7:0]  SERIAL_NO       = 8'h00,
  parameter int unsigned DEBOUNCE_CYCLES = 240000,    // About 5 ms
  parameter int unsigned FLASH_CYCLES    = 10000000
) (
  input  logic                              clk,
  input  logic                              rst_n_i,
  // Command stream
  input  logic                              cmd_rqst_i,
  input  logic [io_cmd_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [io_cmd_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                              cmd_ptt_i,
  input  logic                              cmd_requires_resp_i,
  input  logic                              cmd_ack_ext_i,
  input  logic                              resp_rqst_i,
  output logic [io_cmd_pkg::RESP_W-1:0]     resp_o,
  // Telemetry from the ADC sampler
  input  logic                              adc_valid_i,
  input  io_tlm_pkg::tlm_chan_e             adc_chan_i,
  input  logic [io_tlm_pkg::ADC_W-1:0]      adc_data_i,
  // Keys, active low
  input  logic                              phone_tip_n_i,
  input  logic                              phone_ring_n_i,
  input  logic                              txinhibit_n_i,
  // Status pulses
  input  logic                              rxclip_p_i,
  input  logic                              rxclip_n_i,
  input  logic                              this_mac_i,
  input  logic                              run_i,
  output logic                              cwkey_o,
  output logic                              ext_ptt_o,
  output logic                              txinhibit_o,
  output logic                              db_cwkey_o,
  output logic                              led_d2_o,
  output logic                              led_d3_o,
  output logic                              led_d4_o,
  output logic                              led_d5_o,
  output logic                              pa_inttr_o,
  output logic                              pa_exttr_o,
  output logic                              pwr_envpa_o,
  output logic                              pwr_envop_o,
  output logic                              pwr_envbias_o,
  output logic                              rffe_rfsw_sel_o
);

  logic                         ptt;
  logic                         clip;
  logic [io_tlm_pkg::ADC_W-1:0] fwd_pwr;
  logic [io_tlm_pkg::ADC_W-1:0] temp;
  logic [io_tlm_pkg::ADC_W-1:0] bias;
  logic [io_tlm_pkg::ADC_W-1:0] rev_pwr;

  key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_cwkey (
    .clk, .rst_n_i, .sw_n_i(phone_tip_n_i), .level_o(cwkey_o));
  key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_ptt (
    .clk, .rst_n_i, .sw_n_i(phone_ring_n_i), .level_o(ext_ptt_o));
  key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_txinhibit (
    .clk, .rst_n_i, .sw_n_i(txinhibit_n_i), .level_o(txinhibit_o));

  assign db_cwkey_o = cwkey_o;  // Key monitor pin

  led_flash #(.FLASH_CYCLES(FLASH_CYCLES)) i_led_clip_p (
    .clk, .rst_n_i, .status_i(rxclip_p_i), .led_n_o(led_d4_o));
  led_flash #(.FLASH_CYCLES(FLASH_CYCLES)) i_led_clip_n (
    .clk, .rst_n_i, .status_i(rxclip_n_i), .led_n_o(led_d5_o));
  led_flash #(.FLASH_CYCLES(FLASH_CYCLES)) i_led_mac (
    .clk, .rst_n_i, .status_i(this_mac_i), .led_n_o(led_d2_o));
  led_flash #(.FLASH_CYCLES(FLASH_CYCLES)) i_led_run (
    .clk, .rst_n_i, .status_i(run_i), .led_n_o(led_d3_o));

  // Clip reported while either clip LED is lit
  assign clip = ~led_d4_o | ~led_d5_o;

  tr_control i_tr_control (
    .clk, .rst_n_i,
    .cmd_rqst_i, .cmd_addr_i, .cmd_data_i, .cmd_ptt_i,
    .cwkey_i(cwkey_o), .ext_ptt_i(ext_ptt_o), .txinhibit_i(txinhibit_o),
    .ptt_o(ptt),
    .pa_inttr_o, .pa_exttr_o, .pwr_envpa_o, .pwr_envop_o, .pwr_envbias_o,
    .rfsw_sel_o(rffe_rfsw_sel_o)
  );

  telemetry_regs i_telemetry_regs (
    .clk, .rst_n_i, .adc_valid_i, .adc_chan_i, .adc_data_i,
    .fwd_pwr_o(fwd_pwr), .temp_o(temp), .bias_o(bias), .rev_pwr_o(rev_pwr)
  );

  resp_builder #(.SERIAL_NO(SERIAL_NO)) i_resp_builder (
    .clk, .rst_n_i,
    .cmd_rqst_i, .cmd_addr_i, .cmd_data_i, .cmd_requires_resp_i,
    .cmd_ack_ext_i, .resp_rqst_i,
    .ptt_i(ptt), .clip_i(clip),
    .fwd_pwr_i(fwd_pwr), .temp_i(temp), .bias_i(bias), .rev_pwr_i(rev_pwr),
    .resp_o
  );

endmodule

`default_nettype wire

/* verilog/resp_builder.sv */
`timescale 1ns/100ps
`default_nettype none

module resp_builder #(
  parameter logic [7:0] SERIAL_NO = 8'h00
) (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              cmd_rqst_i,
  input  logic [io_cmd_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [io_cmd_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                              cmd_requires_resp_i,
  input  logic                              cmd_ack_ext_i,
  input  logic                              resp_rqst_i,
  input  logic                              ptt_i,
  input  logic                              clip_i,  // Either clip LED lit
  input  logic [io_tlm_pkg::ADC_W-1:0]      fwd_pwr_i,
  input  logic [io_tlm_pkg::ADC_W-1:0]      temp_i,
  input  logic [io_tlm_pkg::ADC_W-1:0]      bias_i,
  input  logic [io_tlm_pkg::ADC_W-1:0]      rev_pwr_i,
  output logic [io_cmd_pkg::RESP_W-1:0]     resp_o
);

  localparam logic [7:0] ID_BYTE = 8'h1e;  // Board identity
  localparam int PAD_W = io_cmd_pkg::CMD_DATA_W / 2 - io_tlm_pkg::ADC_W;

  logic [io_cmd_pkg::CMD_ADDR_W-1:0] addr_q;
  logic [io_cmd_pkg::CMD_DATA_W-1:0] data_q;
  logic                              req_resp_q;
  logic                              pending_q;
  io_tlm_pkg::resp_slot_e            slot_q;
  logic [io_cmd_pkg::CMD_DATA_W-1:0] payload;

  // Last command, overwritten by the next one
  always_ff @(posedge clk) begin
    if (cmd_rqst_i) begin
      addr_q <= cmd_addr_i;
      data_q <= cmd_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      req_resp_q <= 1'b0;
      pending_q  <= 1'b0;
    end else begin
      if (cmd_rqst_i)
        req_resp_q <= cmd_requires_resp_i;
      // Acknowledge beats a same-cycle request, queue depth one
      if (cmd_ack_ext_i && req_resp_q)
        pending_q <= 1'b1;
      else if (resp_rqst_i)
        pending_q <= 1'b0;
    end
  end

  always_comb begin
    case (slot_q)
      io_tlm_pkg::SLOT_ID:
        payload = {ID_BYTE[7:1], clip_i, 8'h00, 8'h00, SERIAL_NO};
      io_tlm_pkg::SLOT_TEMP_FWD:
        payload = {{PAD_W{1'b0}}, temp_i, {PAD_W{1'b0}}, fwd_pwr_i};
      io_tlm_pkg::SLOT_REV_BIAS:
        payload = {{PAD_W{1'b0}}, rev_pwr_i, {PAD_W{1'b0}}, bias_i};
      default:
        payload = '0;  // Spare slot
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      resp_o <= {8'h00, ID_BYTE, 8'h00, 8'h00, SERIAL_NO};
      slot_q <= io_tlm_pkg::SLOT_ID;
    end else if (resp_rqst_i) begin
      // Slot moves on even when a command response takes its place
      slot_q <= io_tlm_pkg::resp_slot_e'(slot_q + 2'd1);
      if (pending_q)
        resp_o <= {1'b1, addr_q, ptt_i, data_q};
      else
        resp_o <= {3'b000, slot_q, 2'b00, ptt_i, payload};
    end
  end

  a_resp_on_rqst: assert property (@(posedge clk) disable iff (!rst_n_i)
    $changed(resp_o) |-> $past(resp_rqst_i));

endmodule

`default_nettype wire

/* verilog/telemetry_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module telemetry_regs (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         adc_valid_i,
  input  io_tlm_pkg::tlm_chan_e        adc_chan_i,
  input  logic [io_tlm_pkg::ADC_W-1:0] adc_data_i,
  output logic [io_tlm_pkg::ADC_W-1:0] fwd_pwr_o,
  output logic [io_tlm_pkg::ADC_W-1:0] temp_o,
  output logic [io_tlm_pkg::ADC_W-1:0] bias_o,
  output logic [io_tlm_pkg::ADC_W-1:0] rev_pwr_o
);

  // Latest sample per channel
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      fwd_pwr_o <= '0;
      temp_o    <= '0;
      bias_o    <= '0;
      rev_pwr_o <= '0;
    end else if (adc_valid_i) begin
      case (adc_chan_i)
        io_tlm_pkg::CH_FWD_PWR: fwd_pwr_o <= adc_data_i;
        io_tlm_pkg::CH_TEMP:    temp_o    <= adc_data_i;
        io_tlm_pkg::CH_BIAS:    bias_o    <= adc_data_i;
        io_tlm_pkg::CH_REV_PWR: rev_pwr_o <= adc_data_i;
        default: ;
      endcase
    end
  end

  a_chan_known: assert property (@(posedge clk) disable iff (!rst_n_i)
    adc_valid_i |-> !$isunknown(adc_chan_i));

endmodule

`default_nettype wire

/* verilog/tr_control.sv */
`timescale 1ns/100ps
`default_nettype none

module tr_control (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              cmd_rqst_i,
  input  logic [io_cmd_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [io_cmd_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                              cmd_ptt_i,
  input  logic                              cwkey_i,      // Debounced, active high
  input  logic                              ext_ptt_i,
  input  logic                              txinhibit_i,
  output logic                              ptt_o,
  output logic                              pa_inttr_o,
  output logic                              pa_exttr_o,
  output logic                              pwr_envpa_o,
  output logic                              pwr_envop_o,
  output logic                              pwr_envbias_o,
  output logic                              rfsw_sel_o
);

  logic vna_q;
  logic pa_en_q;
  logic tr_dis_q;
  logic cmd_ptt_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      vna_q     <= 1'b0;
      pa_en_q   <= 1'b0;
      tr_dis_q  <= 1'b0;
      cmd_ptt_q <= 1'b0;
    end else if (cmd_rqst_i) begin
      cmd_ptt_q <= cmd_ptt_i;  // Every command carries PTT
      if (cmd_addr_i == io_cmd_pkg::CMD_TR_CFG) begin
        vna_q    <= cmd_data_i[io_cmd_pkg::VNA_BIT];
        pa_en_q  <= cmd_data_i[io_cmd_pkg::PA_EN_BIT];
        tr_dis_q <= cmd_data_i[io_cmd_pkg::TR_DIS_BIT];
      end
    end
  end

  // Any key source keys the radio unless inhibited
  assign ptt_o = (cmd_ptt_q | cwkey_i | ext_ptt_i) & ~txinhibit_i;

  assign pa_exttr_o = ptt_o;

  // Internal T/R relay follows PTT unless bypassed with the PA off
  assign pa_inttr_o = ptt_o & (pa_en_q | ~tr_dis_q);

  assign pwr_envpa_o   = ptt_o & pa_en_q;
  assign pwr_envbias_o = ptt_o & pa_en_q;

  // VNA sweeps need the envelope supply even on receive
  assign pwr_envop_o = ptt_o | (vna_q & ~txinhibit_i);

  assign rfsw_sel_o = pa_en_q;  // Route through the PA path

endmodule

`default_nettype wire

/* verilog/led_flash.sv */
`timescale 1ns/100ps
`default_nettype none

module led_flash #(
  parameter int unsigned FLASH_CYCLES = 10000000
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic status_i,  // Status pulse, any length
  output logic led_n_o    // LED drive, low is lit
);

  localparam int CNT_W = $clog2(FLASH_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(FLASH_CYCLES);

  logic [CNT_W-1:0] cnt;

  // Retrigger while the status is active, then run down
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt <= '0;
    end else if (status_i) begin
      cnt <= CNT_LOAD;
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  // Lit for as long as the timer runs
  assign led_n_o = (cnt == '0);

endmodule

`default_nettype wire

/* verilog/key_debounce.sv */
`timescale 1ns/100ps
`default_nettype none

module key_debounce #(
  parameter int unsigned DEBOUNCE_CYCLES = 240000
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic sw_n_i,   // Raw switch, active low
  output logic level_o   // Clean level, active high
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEBOUNCE_CYCLES);

  logic             sw_meta;
  logic             sw_sync;
  logic             target;
  logic [CNT_W-1:0] cnt;

  assign target = ~sw_sync;  // Level the output is heading for

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sw_meta <= 1'b1;  // Released key
      sw_sync <= 1'b1;
      cnt     <= '0;
      level_o <= 1'b0;
    end else begin
      sw_meta <= sw_n_i;
      sw_sync <= sw_meta;
      if (target == level_o) begin
        cnt <= '0;  // Bounce back, start over
      end else if (cnt == CNT_MAX) begin
        level_o <= target;
        cnt     <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  a_toggle_at_limit: assert property (@(posedge clk) disable iff (!rst_n_i)
    $changed(level_o) |-> $past(cnt) == CNT_MAX);

endmodule

`default_nettype wire

/* verilog/io_tlm_pkg.sv */
`default_nettype none

// Telemetry channels and status slot numbering
package io_tlm_pkg;

  localparam int ADC_W = 12;  // Slow ADC sample width

  // Channel numbers as delivered by the ADC sampler
  typedef enum logic [1:0] {
    CH_FWD_PWR = 2'd0,
    CH_TEMP    = 2'd1,
    CH_BIAS    = 2'd2,
    CH_REV_PWR = 2'd3
  } tlm_chan_e;

  // Round-robin status slots in the response word
  typedef enum logic [1:0] {
    SLOT_ID       = 2'd0,
    SLOT_TEMP_FWD = 2'd1,
    SLOT_REV_BIAS = 2'd2,
    SLOT_SPARE    = 2'd3
  } resp_slot_e;

endpackage

`default_nettype wire

/* verilog/io_cmd_pkg.sv */
`default_nettype none

// Command stream and response word definitions
package io_cmd_pkg;

  // Command field widths
  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;

  // Response word to the host
  localparam int RESP_W = 40;

  // Command addresses decoded by this block
  typedef enum logic [CMD_ADDR_W-1:0] {
    CMD_TR_CFG = 6'h09  // Transmit configuration
  } cmd_addr_e;

  // Bit positions in the data of CMD_TR_CFG
  localparam int VNA_BIT    = 23;
  localparam int PA_EN_BIT  = 19;
  localparam int TR_DIS_BIT = 18;

endpackage

`default_nettype wire
